// File: exu_pkg.sv
`default_nettype none

package exu_pkg;

    // ----------------------------------------------------------------------
    // Widths and basic vector types
    // ----------------------------------------------------------------------
    localparam int unsigned xlen    = 32;     // Data path width
    localparam int unsigned shamt_w = 5;      // Shift amount bits taken from operand b
    localparam int unsigned nregs   = 32;     // Architectural registers x0..x31

    typedef logic [xlen-1:0] word_t;          // Operand, immediate, result
    typedef logic [31:0]     instr_t;         // Raw instruction word
    typedef logic [4:0]      reg_idx_t;       // Register index
    typedef logic [3:0]      alu_op_t;        // ALU function select

    // ----------------------------------------------------------------------
    // ALU operation codes
    // ----------------------------------------------------------------------
    localparam alu_op_t alu_add  = 4'd0;
    localparam alu_op_t alu_sub  = 4'd1;
    localparam alu_op_t alu_and  = 4'd2;
    localparam alu_op_t alu_or   = 4'd3;
    localparam alu_op_t alu_xor  = 4'd4;
    localparam alu_op_t alu_slt  = 4'd5;      // Signed compare
    localparam alu_op_t alu_sltu = 4'd6;      // Unsigned compare
    localparam alu_op_t alu_sll  = 4'd7;
    localparam alu_op_t alu_srl  = 4'd8;
    localparam alu_op_t alu_sra  = 4'd9;      // Sign fill

    // RV32I major opcodes handled here
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;

    // funct3 field values shared by OP and OP-IMM
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct7 values
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;  // sub / sra

    // ----------------------------------------------------------------------
    // Stage bundles
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic     valid;                      // Instruction present
        logic     illegal;                    // Not OP, OP-IMM or LUI, or bad funct7
        alu_op_t  alu_op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;                        // I-type, shamt or U-type
        logic     use_imm;                    // Operand b from imm
        logic     a_zero;                     // Operand a forced to zero (LUI)
        logic     write_en;                   // Legal, writes rd
    } decode_bundle_t;

    typedef struct packed {
        logic     valid;
        logic     illegal;
        reg_idx_t rd;
        word_t    result;
        logic     overflow;
    } wb_bundle_t;

endpackage

`default_nettype wire

// File: op_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module op_decoder (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   instr_valid,
    input  wire exu_pkg::instr_t        instr,
    output exu_pkg::decode_bundle_t     dec
);

    // Instruction fields
    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    exu_pkg::word_t         imm_i;
    exu_pkg::word_t         imm_shamt;
    exu_pkg::word_t         imm_u;
    exu_pkg::decode_bundle_t dec_next;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i     = {{20{instr[31]}}, instr[31:20]};                   // Sign extended
    assign imm_shamt = {{(exu_pkg::xlen - exu_pkg::shamt_w){1'b0}},
                        instr[20 +: exu_pkg::shamt_w]};                   // Zero extended
    assign imm_u     = {instr[31:12], 12'b0};

    // ----------------------------------------------------------------------
    // Combinational decode
    // ----------------------------------------------------------------------
    always_comb begin
        dec_next          = '0;
        dec_next.valid    = 1'b1;
        dec_next.rs1      = instr[19:15];
        dec_next.rs2      = instr[24:20];
        dec_next.rd       = instr[11:7];
        dec_next.alu_op   = exu_pkg::alu_add;
        dec_next.imm      = imm_i;

        case (opcode)
            exu_pkg::opc_op, exu_pkg::opc_op_imm: begin
                dec_next.use_imm = (opcode == exu_pkg::opc_op_imm);
                case (funct3)
                    exu_pkg::f3_add_sub: begin
                        // OP-IMM has no subtract, funct7 belongs to the immediate
                        if (opcode == exu_pkg::opc_op_imm) begin
                            dec_next.alu_op = exu_pkg::alu_add;
                        end else if (funct7 == exu_pkg::f7_alt) begin
                            dec_next.alu_op = exu_pkg::alu_sub;
                        end else begin
                            dec_next.alu_op  = exu_pkg::alu_add;
                            dec_next.illegal = (funct7 != exu_pkg::f7_base);
                        end
                    end
                    exu_pkg::f3_sll: begin
                        dec_next.alu_op  = exu_pkg::alu_sll;
                        dec_next.imm     = imm_shamt;
                        dec_next.illegal = (funct7 != exu_pkg::f7_base);
                    end
                    exu_pkg::f3_srl_sra: begin
                        dec_next.imm     = imm_shamt;
                        dec_next.alu_op  = (funct7 == exu_pkg::f7_alt) ? exu_pkg::alu_sra
                                                                       : exu_pkg::alu_srl;
                        dec_next.illegal = (funct7 != exu_pkg::f7_base) &&
                                           (funct7 != exu_pkg::f7_alt);
                    end
                    exu_pkg::f3_slt:  dec_next.alu_op = exu_pkg::alu_slt;
                    exu_pkg::f3_sltu: dec_next.alu_op = exu_pkg::alu_sltu;
                    exu_pkg::f3_xor:  dec_next.alu_op = exu_pkg::alu_xor;
                    exu_pkg::f3_or:   dec_next.alu_op = exu_pkg::alu_or;
                    default:          dec_next.alu_op = exu_pkg::alu_and;   // f3_and
                endcase
                // Register form checks funct7 for every funct3
                if ((opcode == exu_pkg::opc_op) && (funct7 != exu_pkg::f7_base) &&
                    (funct3 != exu_pkg::f3_add_sub) && (funct3 != exu_pkg::f3_srl_sra)) begin
                    dec_next.illegal = 1'b1;
                end
            end
            exu_pkg::opc_lui: begin
                dec_next.imm     = imm_u;
                dec_next.use_imm = 1'b1;
                dec_next.a_zero  = 1'b1;                                  // 0 + imm
            end
            default: dec_next.illegal = 1'b1;
        endcase

        dec_next.write_en = !dec_next.illegal;
    end

    // Decode register, payload only loads on a strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            dec.valid    <= 1'b0;
            dec.illegal  <= 1'b0;
            dec.write_en <= 1'b0;
        end else if (instr_valid) begin
            dec <= dec_next;
        end else begin
            dec.valid <= 1'b0;                                            // Bubble
        end
    end

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire exu_pkg::reg_idx_t rs1,
    input  wire exu_pkg::reg_idx_t rs2,
    output exu_pkg::word_t         rd1,
    output exu_pkg::word_t         rd2,
    input  wire logic              write_en,
    input  wire exu_pkg::reg_idx_t write_rd,
    input  wire exu_pkg::word_t    write_data
);

    exu_pkg::word_t regs [exu_pkg::nregs];

    // ----------------------------------------------------------------------
    // Write port
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < exu_pkg::nregs; i++) begin
                regs[i] <= '0;                                 // All registers start at zero
            end
        end else if (write_en && (write_rd != '0)) begin
            regs[write_rd] <= write_data;                      // x0 never written
        end
    end

    // Asynchronous reads
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire exu_pkg::decode_bundle_t dec,
    input  wire exu_pkg::word_t          rs1_data,
    input  wire exu_pkg::word_t          rs2_data,
    output exu_pkg::word_t               result,
    output logic                         overflow
);

    localparam int unsigned msb = exu_pkg::xlen - 1;

    exu_pkg::word_t               op_a;
    exu_pkg::word_t               op_b;
    exu_pkg::word_t               b_eff;       // b or ~b
    exu_pkg::word_t               sum;         // Shared adder output
    logic                         sub_sel;     // Subtract / compare
    logic                         add_of;      // Signed overflow of the adder
    logic [exu_pkg::shamt_w-1:0]  shamt;

    // ----------------------------------------------------------------------
    // Operand select
    // ----------------------------------------------------------------------
    assign op_a  = dec.a_zero  ? '0      : rs1_data;    // LUI adds to zero
    assign op_b  = dec.use_imm ? dec.imm : rs2_data;
    assign shamt = op_b[exu_pkg::shamt_w-1:0];          // Upper bits ignored

    // ----------------------------------------------------------------------
    // Adder, shared by add, sub and signed compare
    // ----------------------------------------------------------------------
    assign sub_sel = (dec.alu_op == exu_pkg::alu_sub) || (dec.alu_op == exu_pkg::alu_slt);
    assign b_eff   = sub_sel ? ~op_b : op_b;
    assign sum     = op_a + b_eff + exu_pkg::word_t'(sub_sel);   // Carry in for two's complement

    // Inputs alike in sign after inversion, result sign flipped
    assign add_of = (op_a[msb] == b_eff[msb]) && (sum[msb] != op_a[msb]);

    // ----------------------------------------------------------------------
    // Function select
    // ----------------------------------------------------------------------
    always_comb begin
        overflow = 1'b0;                                // Only add and sub report it
        case (dec.alu_op)
            exu_pkg::alu_add: begin
                result   = sum;
                overflow = add_of;
            end
            exu_pkg::alu_sub: begin
                result   = sum;
                overflow = add_of;
            end
            exu_pkg::alu_and: result = op_a & op_b;
            exu_pkg::alu_or:  result = op_a | op_b;
            exu_pkg::alu_xor: result = op_a ^ op_b;
            exu_pkg::alu_slt: begin
                // Signs differ, a negative means a < b
                if (op_a[msb] != op_b[msb]) begin
                    result = exu_pkg::word_t'(op_a[msb]);
                end else begin
                    result = exu_pkg::word_t'(sum[msb]);   // Same sign, difference sign
                end
            end
            exu_pkg::alu_sltu: begin
                result = exu_pkg::word_t'(op_a < op_b);
            end
            exu_pkg::alu_sll: result = op_a << shamt;
            exu_pkg::alu_srl: result = op_a >> shamt;    // Zero fill
            exu_pkg::alu_sra: begin
                result = exu_pkg::word_t'($signed(op_a) >>> shamt);   // Sign fill
            end
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire exu_pkg::decode_bundle_t dec,
    input  wire exu_pkg::word_t          alu_result,
    input  wire logic                    alu_overflow,
    output logic                         write_en,
    output exu_pkg::reg_idx_t            write_rd,
    output exu_pkg::word_t               write_data,
    output exu_pkg::wb_bundle_t          wb
);

    // Register file write, lands on the same edge as wb
    assign write_en   = dec.valid && dec.write_en;
    assign write_rd   = dec.rd;
    assign write_data = alu_result;

    // ----------------------------------------------------------------------
    // Result register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wb.valid   <= 1'b0;
            wb.illegal <= 1'b0;
        end else begin
            wb.valid   <= dec.valid && !dec.illegal;   // One pulse per legal instruction
            wb.illegal <= dec.valid &&  dec.illegal;
        end
        wb.rd       <= dec.rd;
        wb.result   <= alu_result;
        wb.overflow <= alu_overflow && !dec.illegal;
    end

endmodule

`default_nettype wire

// File: exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              instr_valid,
    input  wire exu_pkg::instr_t   instr,
    output logic                   result_valid,
    output logic                   illegal_instr,
    output exu_pkg::reg_idx_t      result_rd,
    output exu_pkg::word_t         result,
    output logic                   overflow
);

    exu_pkg::decode_bundle_t dec;             // Decode stage register
    exu_pkg::wb_bundle_t     wb;              // Writeback stage register
    exu_pkg::word_t          rs1_data;
    exu_pkg::word_t          rs2_data;
    exu_pkg::word_t          alu_result;
    logic                    alu_overflow;
    logic                    rf_write_en;
    exu_pkg::reg_idx_t       rf_write_rd;
    exu_pkg::word_t          rf_write_data;

    // ----------------------------------------------------------------------
    // Decode, read, execute, write back
    // ----------------------------------------------------------------------
    op_decoder u_dec (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec         (dec)
    );

    reg_file u_rf (
        .clk        (clk),
        .reset      (reset),
        .rs1        (dec.rs1),
        .rs2        (dec.rs2),
        .rd1        (rs1_data),
        .rd2        (rs2_data),
        .write_en   (rf_write_en),
        .write_rd   (rf_write_rd),
        .write_data (rf_write_data)
    );

    alu u_alu (
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    writeback_stage u_wb (
        .clk          (clk),
        .reset        (reset),
        .dec          (dec),
        .alu_result   (alu_result),
        .alu_overflow (alu_overflow),
        .write_en     (rf_write_en),
        .write_rd     (rf_write_rd),
        .write_data   (rf_write_data),
        .wb           (wb)
    );

    // Result ports straight from the wb register
    assign result_valid  = wb.valid;
    assign illegal_instr = wb.illegal;
    assign result_rd     = wb.rd;
    assign result        = wb.result;
    assign overflow      = wb.overflow;

endmodule

`default_nettype wire

// File: exec_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core_properties (
    input wire logic clk,
    input wire logic reset,
    input wire logic dec_valid,
    input wire logic result_valid,
    input wire logic illegal_instr
);

    // ----------------------------------------------------------------------
    // Pipeline timing
    // ----------------------------------------------------------------------
    // Fixed one cycle from decode to a single retire pulse
    a_one_pulse: assert property (@(posedge clk) disable iff (reset)
        dec_valid |=> (result_valid ^ illegal_instr))
        else $error("decoded instruction not retired by exactly one pulse");

    a_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(result_valid && illegal_instr))
        else $error("result_valid and illegal_instr high together");

    // Reset clears both pulses
    a_reset_quiet: assert property (@(posedge clk)
        reset |=> (!result_valid && !illegal_instr))
        else $error("retire pulse seen during reset");

endmodule

bind exec_core exec_core_properties u_props (
    .clk           (clk),
    .reset         (reset),
    .dec_valid     (dec.valid),
    .result_valid  (result_valid),
    .illegal_instr (illegal_instr)
);

`default_nettype wire

// File: exec_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb;

    localparam int num_instr  = 400;
    localparam int timeout_ns = (num_instr + 50) * 10 * 2;   // Generous bound on the run

    // Expected outcome of one instruction
    typedef struct packed {
        logic              illegal;
        exu_pkg::reg_idx_t rd;
        exu_pkg::word_t    result;
        logic              overflow;
    } outcome_t;

    logic              clk;
    logic              reset;
    logic              instr_valid;
    exu_pkg::instr_t   instr;
    logic              result_valid;
    logic              illegal_instr;
    exu_pkg::reg_idx_t result_rd;
    exu_pkg::word_t    result;
    logic              overflow;

    exu_pkg::word_t    model_regs [32];    // Testbench copy of the register file
    outcome_t          exp_q [$];          // Issued and not yet retired
    int                n_checked;
    int unsigned       seed;

    exec_core u_dut (
        .clk           (clk),
        .reset         (reset),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .result_valid  (result_valid),
        .illegal_instr (illegal_instr),
        .result_rd     (result_rd),
        .result        (result),
        .overflow      (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Failure reporting and the compare helper
    // ----------------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_value(input string name, input exu_pkg::word_t expected,
                               input exu_pkg::word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // ----------------------------------------------------------------------
    // Reference model with the RV32I rules for OP, OP-IMM and LUI
    // ----------------------------------------------------------------------
    function automatic outcome_t predict(input exu_pkg::instr_t ins);
        outcome_t       o;
        logic [6:0]     opc;
        logic [6:0]     f7;
        logic [2:0]     f3;
        exu_pkg::word_t a;
        exu_pkg::word_t b;
        exu_pkg::word_t r;
        logic           legal;
        opc = ins[6:0];
        f3  = ins[14:12];
        f7  = ins[31:25];
        o    = '0;
        o.rd = ins[11:7];
        r    = '0;
        a    = model_regs[ins[19:15]];
        b    = (opc == exu_pkg::opc_op) ? model_regs[ins[24:20]]
                                        : {{20{ins[31]}}, ins[31:20]};  // I-type imm
        if (opc == exu_pkg::opc_lui) begin
            r = {ins[31:12], 12'h000};
        end else if ((opc == exu_pkg::opc_op) || (opc == exu_pkg::opc_op_imm)) begin
            if (opc == exu_pkg::opc_op) begin
                legal = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
            end else if (f3 == 3'd1) begin
                legal = (f7 == 7'h00);                      // slli
            end else if (f3 == 3'd5) begin
                legal = (f7 == 7'h00) || (f7 == 7'h20);     // srli / srai
            end else begin
                legal = 1'b1;                               // funct7 is part of the imm
            end
            o.illegal = !legal;
            case (f3)
                3'd0: begin
                    if ((opc == exu_pkg::opc_op) && (f7 == 7'h20)) begin
                        r          = a - b;
                        o.overflow = (a[31] != b[31]) && (r[31] != a[31]);
                    end else begin
                        r          = a + b;
                        o.overflow = (a[31] == b[31]) && (r[31] != a[31]);
                    end
                end
                3'd1: r = a << b[4:0];
                3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: r = (a < b) ? 32'd1 : 32'd0;
                3'd4: r = a ^ b;
                3'd5: begin
                    if (f7[5]) begin
                        r = $signed(a) >>> b[4:0];          // Sign fill
                    end else begin
                        r = a >> b[4:0];
                    end
                end
                3'd6: r = a | b;
                default: r = a & b;
            endcase
        end else begin
            o.illegal = 1'b1;                               // Unknown opcode
        end
        o.result = r;
        if (!o.illegal && (o.rd != '0)) begin
            model_regs[o.rd] = r;                           // x0 stays zero
        end
        return o;
    endfunction

    // Random instruction on registers x0..x7 only
    function automatic exu_pkg::instr_t random_instr();
        exu_pkg::instr_t   ins;
        exu_pkg::reg_idx_t rd;
        exu_pkg::reg_idx_t rs1;
        exu_pkg::reg_idx_t rs2;
        logic [6:0]        f7;
        logic [2:0]        f3;
        logic [6:0]        opc;
        int unsigned       pick;
        rd   = exu_pkg::reg_idx_t'($urandom % 8);
        rs1  = exu_pkg::reg_idx_t'($urandom % 8);
        rs2  = exu_pkg::reg_idx_t'($urandom % 8);
        f3   = 3'($urandom);
        pick = $urandom % 8;
        // Odd funct7 now and then
        f7   = (pick < 5) ? 7'h00 : ((pick < 7) ? 7'h20 : 7'($urandom));
        pick = $urandom % 8;
        if (pick < 3) begin
            ins = {f7, rs2, rs1, f3, rd, exu_pkg::opc_op};
        end else if (pick < 6) begin
            if ((f3 == 3'd1) || (f3 == 3'd5)) begin
                ins = {f7, 5'($urandom), rs1, f3, rd, exu_pkg::opc_op_imm};  // Shift imm
            end else begin
                ins = {12'($urandom), rs1, f3, rd, exu_pkg::opc_op_imm};
            end
        end else if (pick == 6) begin
            ins = {20'($urandom), rd, exu_pkg::opc_lui};
        end else begin
            opc = 7'($urandom);
            while ((opc == exu_pkg::opc_op) || (opc == exu_pkg::opc_op_imm) ||
                   (opc == exu_pkg::opc_lui)) begin
                opc = 7'($urandom);
            end
            ins      = $urandom;
            ins[6:0] = opc;
        end
        return ins;
    endfunction

    // ----------------------------------------------------------------------
    // Stimulus driven on the falling edge
    // ----------------------------------------------------------------------
    initial begin
        int issued;
        exu_pkg::instr_t ins;
        seed        = $urandom(2917);
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        n_checked   = 0;
        issued      = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;                             // Matches the reset state
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (issued < num_instr) begin
            @(negedge clk);
            if (($urandom % 5) == 0) begin
                instr_valid = 1'b0;                         // Idle cycle
                instr       = $urandom;
            end else begin
                ins         = random_instr();
                instr       = ins;
                instr_valid = 1'b1;
                exp_q.push_back(predict(ins));
                issued++;
            end
        end
        @(negedge clk);
        instr_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);                                 // Drain the pipe
        end
        repeat (3) @(negedge clk);                          // Room for stray pulses
        $display("sim passed");
        $finish;
    end

    // Compare process samples outputs half a cycle after they change
    always @(negedge clk) begin
        outcome_t exp;
        if (!reset && (result_valid || illegal_instr)) begin
            if (exp_q.size() == 0) begin
                abort_run("A result pulse arrived with no instruction outstanding");
            end else begin
                exp = exp_q.pop_front();
                n_checked++;
                check_value($sformatf("instr %0d illegal", n_checked), exp.illegal,
                            illegal_instr);
                check_value($sformatf("instr %0d valid", n_checked), !exp.illegal, result_valid);
                if (!exp.illegal) begin
                    check_value($sformatf("instr %0d rd", n_checked), exp.rd, result_rd);
                    check_value($sformatf("instr %0d result", n_checked), exp.result, result);
                    check_value($sformatf("instr %0d overflow", n_checked), exp.overflow,
                                overflow);
                end
            end
        end
    end

    // Watchdog
    initial begin
        #(timeout_ns);
        abort_run("Timeout, the run did not finish and the DUT appears to hang");
    end

endmodule

`default_nettype wire

// File: exec_core.f
exu_pkg.sv
op_decoder.sv
reg_file.sv
alu.sv
writeback_stage.sv
exec_core.sv
exec_core_properties.sv
exec_core_tb.sv
